// File: spy_core_pkg.sv
// Machine definitions for the microcoded core.
// Covers word sizes, microinstruction fields, ALU codes and sequencer states.

package spy_core_pkg;

   // ########################################################################
   // Data path sizes
   // ########################################################################

   localparam int DATA_W    = 32;          // Machine word.
   localparam int NUM_REGS  = 4;           // A, M, MD, VMA.
   localparam int REG_SEL_W = 2;           // Register index.
   localparam int IR_W      = 16;          // Microinstruction.
   localparam int PC_W      = 14;          // Program counter.

   // ########################################################################
   // Microinstruction fields
   // ########################################################################

   localparam int IR_ALU_HI  = 15;         // ALU operation.
   localparam int IR_ALU_LO  = 14;
   localparam int IR_SRCA_HI = 13;         // A operand select.
   localparam int IR_SRCA_LO = 12;
   localparam int IR_SRCM_HI = 11;         // M operand select.
   localparam int IR_SRCM_LO = 10;
   localparam int IR_DEST_HI = 9;          // Writeback destination.
   localparam int IR_DEST_LO = 8;
   localparam int IR_WB      = 7;          // Writeback enable.
   // Bits 6 down to 0 carry nothing yet.

   // ALU operation codes. SUB is A operand minus M operand.
   localparam logic [1:0] ALU_ADD = 2'd0;
   localparam logic [1:0] ALU_SUB = 2'd1;
   localparam logic [1:0] ALU_AND = 2'd2;
   localparam logic [1:0] ALU_XOR = 2'd3;

   // Host load selector for the IR. Values 0..3 pick a cell.
   localparam logic [2:0] LOAD_IR = 3'd4;

   // ########################################################################
   // Sequencer states
   // ########################################################################

   localparam logic [2:0] ST_IDLE   = 3'd0;
   localparam logic [2:0] ST_DECODE = 3'd1;
   localparam logic [2:0] ST_READ   = 3'd2;
   localparam logic [2:0] ST_ALU    = 3'd3;
   localparam logic [2:0] ST_WRITE  = 3'd4;

endpackage

// File: spy_bus_pkg.sv
// Spy port definitions.
// Address map of the 16-bit examine port and layout of the flag word.

package spy_bus_pkg;

   localparam int SPY_W      = 16;         // Read port width.
   localparam int SPY_ADDR_W = 5;          // Spy address width.

   localparam logic [SPY_W-1:0] SPY_IDLE = '1;  // Not reading or unassigned.

   // ########################################################################
   // Address map
   // ########################################################################

   localparam logic [SPY_ADDR_W-1:0] SPY_IR       = 5'd0;
   localparam logic [SPY_ADDR_W-1:0] SPY_OBH_LAST = 5'd1;   // Latched ob.
   localparam logic [SPY_ADDR_W-1:0] SPY_OBL_LAST = 5'd2;
   localparam logic [SPY_ADDR_W-1:0] SPY_OBH      = 5'd3;   // Live ob.
   localparam logic [SPY_ADDR_W-1:0] SPY_OBL      = 5'd4;

   // Cell k high half at base plus 2k, low half one above it.
   localparam logic [SPY_ADDR_W-1:0] SPY_REG_BASE = 5'd5;

   localparam logic [SPY_ADDR_W-1:0] SPY_FLAG     = 5'd13;
   localparam logic [SPY_ADDR_W-1:0] SPY_OPC      = 5'd14;
   localparam logic [SPY_ADDR_W-1:0] SPY_PC       = 5'd15;
   // 16 and up read as idle.

   // ########################################################################
   // Flag word layout
   // ########################################################################

   localparam int FLAG_BUSY_BIT = 15;      // Sequencer running.
   localparam int FLAG_STATE_HI = 14;      // State code.
   localparam int FLAG_STATE_LO = 12;
   localparam int FLAG_MOD_LO   = 0;       // Modified flags, cell k at bit k.

endpackage

// File: micro_sequencer.sv
// Step sequencer for the microcoded core.
// Decodes host loads, runs the four execution states and keeps PC and old PC.

module micro_sequencer (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                load,
   input  logic [2:0]                          load_sel,
   input  logic [spy_core_pkg::IR_W-1:0]       load_data,
   input  logic                                step,
   output logic [spy_core_pkg::IR_W-1:0]       ir,
   output logic [spy_core_pkg::PC_W-1:0]       pc,
   output logic [spy_core_pkg::PC_W-1:0]       opc,
   output logic [2:0]                          state,
   output logic                                busy,
   output logic                                state_write,
   output logic [spy_core_pkg::NUM_REGS-1:0]   cell_load,
   output logic [spy_core_pkg::NUM_REGS-1:0]   cell_wb
);

   import spy_core_pkg::*;

   logic                 idle;
   logic                 load_ok;
   logic [REG_SEL_W-1:0] dest;
   logic [2:0]           state_next;

   assign idle        = (state == ST_IDLE);
   assign busy        = !idle;
   assign state_write = (state == ST_WRITE);
   assign load_ok     = load && idle;            // Loads while busy are dropped.
   assign dest        = ir[IR_DEST_HI:IR_DEST_LO];

   // ########################################################################
   // Cell enables
   // ########################################################################

   always_comb begin
      for (int k = 0; k < NUM_REGS; k++) begin
         cell_load[k] = load_ok && (load_sel == 3'(k));
         cell_wb[k]   = state_write && ir[IR_WB] && (dest == REG_SEL_W'(k));
      end
   end

   // ########################################################################
   // State machine
   // ########################################################################

   always_comb begin
      state_next = state;
      case (state)
         ST_IDLE: begin
            if (step) begin
               state_next = ST_DECODE;           // Step only taken when idle.
            end
         end
         ST_DECODE: state_next = ST_READ;
         ST_READ:   state_next = ST_ALU;
         ST_ALU:    state_next = ST_WRITE;
         ST_WRITE:  state_next = ST_IDLE;
         default:   state_next = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_IDLE;
         ir    <= '0;
         pc    <= '0;
         opc   <= '0;
      end else begin
         state <= state_next;
         if (load_ok && (load_sel == LOAD_IR)) begin
            ir <= load_data;
         end
         // Retire the microinstruction.
         if (state_write) begin
            opc <= pc;
            pc  <= pc + 1'b1;                    // Wraps at 14 bits.
         end
      end
   end

endmodule

// File: reg_cell.sv
// One machine register with host load, writeback and a sticky modified flag.

module reg_cell (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              load,
   input  logic                              wb,
   input  logic                              read_clear,
   input  logic [spy_core_pkg::DATA_W-1:0]   load_data,
   input  logic [spy_core_pkg::DATA_W-1:0]   ob,
   output logic [spy_core_pkg::DATA_W-1:0]   value,
   output logic                              mod_flag
);

   logic write;

   assign write = load || wb;

   // Host load wins over writeback.
   always_ff @(posedge clk) begin
      if (reset) begin
         value <= '0;
      end else if (load) begin
         value <= load_data;
      end else if (wb) begin
         value <= ob;                            // Result of the step.
      end
   end

   // A write at the same edge as a clear keeps the flag set.
   always_ff @(posedge clk) begin
      if (reset) begin
         mod_flag <= 1'b0;
      end else if (write) begin
         mod_flag <= 1'b1;
      end else if (read_clear) begin
         mod_flag <= 1'b0;                       // Host saw the low half.
      end
   end

endmodule

// File: micro_alu.sv
// Operand selection and ALU.
// Picks the A and M operands from the cells and produces the live ob.

module micro_alu (
   input  logic [spy_core_pkg::NUM_REGS-1:0][spy_core_pkg::DATA_W-1:0] reg_file,
   input  logic [spy_core_pkg::IR_W-1:0]                               ir,
   output logic [spy_core_pkg::DATA_W-1:0]                             ob
);

   import spy_core_pkg::*;

   logic [REG_SEL_W-1:0] srca;
   logic [REG_SEL_W-1:0] srcm;
   logic [1:0]           alu_op;
   logic [DATA_W-1:0]    opa;
   logic [DATA_W-1:0]    opm;

   // ########################################################################
   // Field decode
   // ########################################################################

   assign srca   = ir[IR_SRCA_HI:IR_SRCA_LO];
   assign srcm   = ir[IR_SRCM_HI:IR_SRCM_LO];
   assign alu_op = ir[IR_ALU_HI:IR_ALU_LO];

   assign opa = reg_file[srca];                  // A operand.
   assign opm = reg_file[srcm];                  // M operand.

   // ########################################################################
   // Operation
   // ########################################################################

   always_comb begin
      case (alu_op)
         ALU_ADD: ob = opa + opm;
         ALU_SUB: ob = opa - opm;                // Wraps at 32 bits.
         ALU_AND: ob = opa & opm;
         ALU_XOR: ob = opa ^ opm;
         default: ob = '0;
      endcase
   end

endmodule

// File: spy_examine.sv
// Examine port for the host.
// Latches ob at writeback and muxes the addressed 16-bit view onto the spy bus.

module spy_examine (
   input  logic                                                        clk,
   input  logic                                                        reset,
   input  logic                                                        dbread,
   input  logic [spy_bus_pkg::SPY_ADDR_W-1:0]                          spy_addr,
   input  logic                                                        state_write,
   input  logic [spy_core_pkg::DATA_W-1:0]                             ob,
   input  logic [spy_core_pkg::IR_W-1:0]                               ir,
   input  logic [spy_core_pkg::NUM_REGS-1:0][spy_core_pkg::DATA_W-1:0] reg_file,
   input  logic [spy_core_pkg::NUM_REGS-1:0]                           mod_flags,
   input  logic [2:0]                                                  state,
   input  logic                                                        busy,
   input  logic [spy_core_pkg::PC_W-1:0]                               pc,
   input  logic [spy_core_pkg::PC_W-1:0]                               opc,
   output logic [spy_bus_pkg::SPY_W-1:0]                               spy_data,
   output logic [spy_core_pkg::NUM_REGS-1:0]                           read_clear
);

   import spy_core_pkg::*;
   import spy_bus_pkg::*;

   logic [DATA_W-1:0] ob_last;
   logic [SPY_W-1:0]  flag_word;
   logic [SPY_W-1:0]  spy_mux;

   // ########################################################################
   // Latched ob
   // ########################################################################

   // Captured as the step retires.
   always_ff @(posedge clk) begin
      if (reset) begin
         ob_last <= '0;
      end else if (state_write) begin
         ob_last <= ob;
      end
   end

   // ########################################################################
   // Flag word
   // ########################################################################

   always_comb begin
      flag_word                                 = '0;
      flag_word[FLAG_BUSY_BIT]                  = busy;
      flag_word[FLAG_STATE_HI:FLAG_STATE_LO]    = state;
      flag_word[FLAG_MOD_LO +: NUM_REGS]        = mod_flags;
   end

   // ########################################################################
   // Read mux
   // ########################################################################

   always_comb begin
      spy_mux = SPY_IDLE;                        // Unassigned addresses.
      case (spy_addr)
         SPY_IR:       spy_mux = ir;
         SPY_OBH_LAST: spy_mux = ob_last[DATA_W-1:DATA_W-SPY_W];
         SPY_OBL_LAST: spy_mux = ob_last[SPY_W-1:0];
         SPY_OBH:      spy_mux = ob[DATA_W-1:DATA_W-SPY_W];
         SPY_OBL:      spy_mux = ob[SPY_W-1:0];
         SPY_FLAG:     spy_mux = flag_word;
         SPY_OPC:      spy_mux = {{(SPY_W-PC_W){1'b0}}, opc};
         SPY_PC:       spy_mux = {{(SPY_W-PC_W){1'b0}}, pc};
         default:      spy_mux = SPY_IDLE;
      endcase

      // Register halves, high half first.
      for (int k = 0; k < NUM_REGS; k++) begin
         if (spy_addr == SPY_ADDR_W'(SPY_REG_BASE + 2 * k)) begin
            spy_mux = reg_file[k][DATA_W-1:DATA_W-SPY_W];
         end
         if (spy_addr == SPY_ADDR_W'(SPY_REG_BASE + 2 * k + 1)) begin
            spy_mux = reg_file[k][SPY_W-1:0];
         end
      end
   end

   // Reading a low half clears that cell's modified flag at the next edge.
   always_comb begin
      for (int k = 0; k < NUM_REGS; k++) begin
         read_clear[k] = dbread && (spy_addr == SPY_ADDR_W'(SPY_REG_BASE + 2 * k + 1));
      end
   end

   assign spy_data = dbread ? spy_mux : SPY_IDLE;

endmodule

// File: spy_core_top.sv
// Core top level.
// Ties the sequencer, the register cells, the ALU and the examine port together.

module spy_core_top (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                load,
   input  logic [2:0]                          load_sel,
   input  logic [spy_core_pkg::DATA_W-1:0]     load_data,
   input  logic                                step,
   input  logic                                dbread,
   input  logic [spy_bus_pkg::SPY_ADDR_W-1:0]  spy_addr,
   output logic [spy_bus_pkg::SPY_W-1:0]       spy_data
);

   import spy_core_pkg::*;

   logic [IR_W-1:0]                    ir;
   logic [PC_W-1:0]                    pc;
   logic [PC_W-1:0]                    opc;
   logic [2:0]                         state;
   logic                               busy;
   logic                               state_write;
   logic [NUM_REGS-1:0]                cell_load;
   logic [NUM_REGS-1:0]                cell_wb;
   logic [NUM_REGS-1:0]                mod_flags;
   logic [NUM_REGS-1:0]                read_clear;
   logic [NUM_REGS-1:0][DATA_W-1:0]    reg_file;
   logic [DATA_W-1:0]                  ob;

   micro_sequencer micro_sequencer_inst (
      .clk(clk), .reset(reset), .load(load), .load_sel(load_sel),
      .load_data(load_data[IR_W-1:0]),   // IR takes the low bits.
      .step(step), .ir(ir), .pc(pc), .opc(opc), .state(state), .busy(busy),
      .state_write(state_write), .cell_load(cell_load), .cell_wb(cell_wb)
   );

   // A, M, MD and VMA.
   for (genvar k = 0; k < NUM_REGS; k++) begin : g_cell
      reg_cell reg_cell_inst (
         .clk(clk), .reset(reset), .load(cell_load[k]), .wb(cell_wb[k]),
         .read_clear(read_clear[k]), .load_data(load_data), .ob(ob),
         .value(reg_file[k]), .mod_flag(mod_flags[k])
      );
   end

   micro_alu micro_alu_inst (
      .reg_file(reg_file), .ir(ir), .ob(ob)
   );

   spy_examine spy_examine_inst (
      .clk(clk), .reset(reset), .dbread(dbread), .spy_addr(spy_addr),
      .state_write(state_write), .ob(ob), .ir(ir), .reg_file(reg_file),
      .mod_flags(mod_flags), .state(state), .busy(busy), .pc(pc), .opc(opc),
      .spy_data(spy_data), .read_clear(read_clear)
   );

endmodule

// File: spy_core_properties.sv
// Concurrent checks on the sequencer outputs and the spy port.

module spy_core_properties (
   input logic                              clk,
   input logic                              reset,
   input logic                              state_write,
   input logic                              dbread,
   input logic [spy_core_pkg::PC_W-1:0]     pc,
   input logic [spy_bus_pkg::SPY_W-1:0]     spy_data
);

   import spy_core_pkg::*;
   import spy_bus_pkg::*;

   // Write state lasts exactly one cycle.
   write_one_cycle: assert property (@(posedge clk) disable iff (reset)
      state_write |=> !state_write)
      else $error("state_write high for two cycles");

   no_read_idle: assert property (@(posedge clk) disable iff (reset)
      !dbread |-> (spy_data == SPY_IDLE))
      else $error("spy_data not idle without dbread");

   pc_advance: assert property (@(posedge clk) disable iff (reset)
      state_write |=> (pc == PC_W'($past(pc) + PC_W'(1))))
      else $error("pc did not advance after writeback");

endmodule

// Sequencer outputs are visible at the examine block's ports.
bind spy_examine spy_core_properties spy_core_properties_inst (
   .clk(clk), .reset(reset), .state_write(state_write), .dbread(dbread),
   .pc(pc), .spy_data(spy_data)
);

// File: tb_spy_core.sv
// Testbench for the spy core.
// Runs the commands of the data file, keeps a model of the machine and checks the spy port.

module tb_spy_core;

   import spy_core_pkg::*;
   import spy_bus_pkg::*;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 10;
   localparam int SAMPLE_DELAY = 25;        // After the falling edge.
   localparam int STEP_TIMEOUT = 20;        // In cycles.
   localparam int BUSY_CYCLES  = 4;         // DECODE through WRITE.
   localparam int MAX_CMDS     = 64;

   logic                  clk;
   logic                  reset;
   logic                  load;
   logic [2:0]            load_sel;
   logic [DATA_W-1:0]     load_data;
   logic                  step;
   logic                  dbread;
   logic [SPY_ADDR_W-1:0] spy_addr;
   logic [SPY_W-1:0]      spy_data;

   logic [31:0]           cmd_mem [0:3*MAX_CMDS-1];

   // Machine model.
   logic [DATA_W-1:0]     m_reg [0:NUM_REGS-1];
   logic [IR_W-1:0]       m_ir;
   logic [PC_W-1:0]       m_pc;
   logic [PC_W-1:0]       m_opc;
   logic [DATA_W-1:0]     m_ob_last;
   logic [NUM_REGS-1:0]   m_mod;

   spy_core_top spy_core_top_inst (
      .clk(clk), .reset(reset), .load(load), .load_sel(load_sel),
      .load_data(load_data), .step(step), .dbread(dbread),
      .spy_addr(spy_addr), .spy_data(spy_data)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2);
         clk = ~clk;
      end
   end

   // ########################################################################
   // Checking and prediction
   // ########################################################################

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, actual, expected);
         $display("CHECKS FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   // ob from the model cells by the ALU rules.
   function automatic logic [DATA_W-1:0] alu_result(input logic [IR_W-1:0] ir_word);
      logic [DATA_W-1:0] opa;
      logic [DATA_W-1:0] opm;
      logic [DATA_W-1:0] res;
      opa = m_reg[ir_word[13:12]];
      opm = m_reg[ir_word[11:10]];
      case (ir_word[15:14])
         2'd0:    res = opa + opm;
         2'd1:    res = opa - opm;      // Wraps at 32 bits.
         2'd2:    res = opa & opm;
         default: res = opa ^ opm;
      endcase
      return res;
   endfunction

   // Spy word at an address while the sequencer is idle.
   function automatic logic [SPY_W-1:0] predict_spy(input logic [SPY_ADDR_W-1:0] addr);
      logic [DATA_W-1:0] live;
      logic [SPY_W-1:0]  word;
      int                idx;
      live = alu_result(m_ir);
      idx  = int'(addr) - 5;
      word = '1;
      if (addr == 5'd0) word = m_ir;
      else if (addr == 5'd1) word = m_ob_last[31:16];
      else if (addr == 5'd2) word = m_ob_last[15:0];
      else if (addr == 5'd3) word = live[31:16];
      else if (addr == 5'd4) word = live[15:0];
      else if (addr <= 5'd12) word = idx[0] ? m_reg[idx / 2][15:0] : m_reg[idx / 2][31:16];
      else if (addr == 5'd13) word = {12'd0, m_mod};
      else if (addr == 5'd14) word = {2'b00, m_opc};
      else if (addr == 5'd15) word = {2'b00, m_pc};
      return word;
   endfunction

   // ########################################################################
   // Host commands
   // ########################################################################

   task automatic host_load(input logic [2:0] sel, input logic [DATA_W-1:0] value);
      @(negedge clk);
      load      = 1'b1;
      load_sel  = sel;
      load_data = value;
      @(negedge clk);
      load = 1'b0;
      if (sel < 3'd4) begin
         m_reg[sel[1:0]] = value;
         m_mod[sel[1:0]] = 1'b1;
      end else if (sel == 3'd4) begin
         m_ir = value[IR_W-1:0];
      end
   endtask

   // One spy read compared with the expected word.
   task automatic compare_spy_word(input logic [SPY_ADDR_W-1:0] addr,
                                   input logic [SPY_W-1:0] expect_word, input logic reading);
      int idx;
      @(negedge clk);
      dbread   = reading;
      spy_addr = addr;
      #SAMPLE_DELAY;
      check_equal(32'(spy_data), 32'(expect_word), $sformatf("spy_data at address %0d", addr));
      @(negedge clk);
      dbread = 1'b0;
      idx    = int'(addr) - 5;
      if (reading && addr >= 5'd5 && addr <= 5'd12 && idx[0]) begin
         m_mod[idx / 2] = 1'b0;          // Low half read.
      end
   endtask

   task automatic spy_read(input logic [SPY_ADDR_W-1:0] addr, input logic [SPY_W-1:0] expect_word,
                           input logic reading);
      logic [SPY_W-1:0] model_word;
      model_word = reading ? predict_spy(addr) : 16'hFFFF;
      check_equal(32'(expect_word), 32'(model_word),
                  $sformatf("file entry for address %0d", addr));
      compare_spy_word(addr, expect_word, reading);
   endtask

   // Every address compared with the model.
   task automatic sweep_all_addresses(input logic with_low);
      int idx;
      for (int a = 0; a < 32; a++) begin
         idx = a - 5;
         if (with_low || a < 5 || a > 12 || !idx[0]) begin   // Low-half reads clear flags.
            compare_spy_word(SPY_ADDR_W'(a), predict_spy(SPY_ADDR_W'(a)), 1'b1);
         end
      end
   endtask

   // Optionally tries a load and a second step while the first one runs.
   task automatic run_step(input logic disturb, input logic [2:0] sel,
                           input logic [DATA_W-1:0] value);
      logic [DATA_W-1:0] result;
      logic [SPY_W-1:0]  flags;
      int                cycles;
      result = alu_result(m_ir);
      @(negedge clk);
      step = 1'b1;
      @(negedge clk);
      step      = disturb;
      load      = disturb;
      load_sel  = sel;
      load_data = value;
      dbread    = 1'b1;
      spy_addr  = 5'd13;
      #SAMPLE_DELAY;
      flags = spy_data;
      check_equal(32'(flags[15]), 32'd1, "busy bit after step");
      check_equal(32'(flags[14:12]), 32'd1, "state code after step");
      cycles = 0;
      while (flags[15]) begin
         if (cycles >= STEP_TIMEOUT) begin
            $display("Timeout: sequencer still busy after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $fatal(1, "step did not finish");
         end
         @(negedge clk);
         step = 1'b0;
         load = 1'b0;
         #SAMPLE_DELAY;
         flags = spy_data;
         cycles++;
      end
      check_equal(32'(cycles), 32'(BUSY_CYCLES), "busy cycles of a step");
      @(negedge clk);
      dbread = 1'b0;
      if (m_ir[7]) begin
         m_reg[m_ir[9:8]] = result;
         m_mod[m_ir[9:8]] = 1'b1;
      end
      m_ob_last = result;
      m_opc     = m_pc;
      m_pc      = m_pc + 14'd1;
   endtask

   // ########################################################################
   // Command loop
   // ########################################################################

   initial begin : main_seq
      int          n;
      logic [31:0] op;
      logic [31:0] arg;
      logic [31:0] val;
      reset       = 1'b1;
      load        = 1'b0;
      load_sel    = 3'd0;
      load_data   = '0;
      step        = 1'b0;
      dbread      = 1'b0;
      spy_addr    = '0;
      for (int k = 0; k < NUM_REGS; k++) begin
         m_reg[k] = '0;
      end
      m_ir      = '0;
      m_pc      = '0;
      m_opc     = '0;
      m_ob_last = '0;
      m_mod     = '0;
      for (int k = 0; k < 3 * MAX_CMDS; k++) begin
         cmd_mem[k] = '0;                // Unused entries end the run.
      end
      $readmemh("spy_core_input.txt", cmd_mem);
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      sweep_all_addresses(1'b1);         // Reset values.

      n  = 0;
      op = 32'd1;
      while (op != 32'd0 && n < MAX_CMDS) begin
         op  = cmd_mem[3 * n];
         arg = cmd_mem[3 * n + 1];
         val = cmd_mem[3 * n + 2];
         case (op)
            32'd0: ;
            32'd1: begin
               host_load(arg[2:0], val);
               sweep_all_addresses(1'b0);
            end
            32'd2: run_step(1'b0, 3'd0, '0);
            32'd3: spy_read(arg[4:0], val[15:0], 1'b1);
            32'd4: run_step(1'b1, arg[2:0], val);
            32'd5: spy_read(arg[4:0], val[15:0], 1'b0);
            default: begin
               $display("Unknown command %0d in the data file", op);
               $display("CHECKS FAILED");
               $fatal(1, "bad data file");
            end
         endcase
         n++;
      end
      sweep_all_addresses(1'b1);         // Final state.

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// File: spy_core_input.txt
// Columns: op arg value. op 1 load (sel, data), 2 step, 3 read (addr, expected),
// 4 step with a load (sel, data) and a step while busy, 5 read with dbread low, 0 end.
3 00 0000
3 02 0000
3 04 0000
3 0C 0000
3 0D 0000
3 0F 0000
3 14 FFFF
5 0E FFFF
1 0 12345678
1 1 00000009
1 2 DEADBEEF
1 3 0000FFFF
1 6 CAFEF00D
3 05 1234
3 0D 000F
3 06 5678
3 0D 000E
// SUB M minus A into MD with writeback.
1 4 00005280
3 04 A991
2 0 0
3 0A A991
3 01 EDCB
3 0E 0000
3 0F 0001
3 0D 000A
// XOR VMA with A, writeback off.
1 4 0000F100
3 03 1234
2 0 0
3 08 0009
3 02 A987
3 0D 0008
4 0 FFFFFFFF
3 0D 0008
3 06 5678
3 0F 0003
0 0 0

// File: vlog.f
spy_core_pkg.sv
spy_bus_pkg.sv
micro_sequencer.sv
reg_cell.sv
micro_alu.sv
spy_examine.sv
spy_core_top.sv
spy_core_properties.sv
tb_spy_core.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the spy core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f vlog.f --top-module tb_spy_core
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

output=$(./obj_dir/Vtb_spy_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
exit 1
